/* edge_filter_defines.svh */
`ifndef EDGE_FILTER_DEFINES_SVH
`define EDGE_FILTER_DEFINES_SVH

// Pixel and channel widths, 4 bits per RGB channel
`define EF_PIX_W 12
`define EF_CH_W 4

// Signed channel sum, wide enough for the 5x5 extremes of +-270
`define EF_SUM_W 10

// Largest kernel side
`define EF_KERNEL_N 5

// Edge thresholds per kernel size
`define EF_THRESH_3X3 32
`define EF_THRESH_5X5 64

// Register stages inside the execute block
`define EF_EXEC_DEPTH 2

`define EF_LINE_WIDTH 320

`endif

/* edge_filter_pkg.sv */
`include "edge_filter_defines.svh"

package edge_filter_pkg;

    // Red in the top nibble, then green, then blue
    typedef logic [`EF_PIX_W-1:0] pixel_t;

    typedef logic [`EF_CH_W-1:0] channel_t;

    typedef logic signed [`EF_SUM_W-1:0] sum_t;

    // Signed kernel weight, range -4 to 4
    typedef logic signed [3:0] weight_t;

    typedef enum logic [1:0] {
        MODE_PASS    = 2'd0,
        MODE_3X3     = 2'd1,
        MODE_5X5     = 2'd2,
        MODE_5X5_ALT = 2'd3
    } mode_t;

    typedef struct packed {
        logic  valid;
        logic  sop;
        logic  eop;
        mode_t mode;
    } sideband_t;

    // Vertical gradient, row 0 positive and row 4 negative
    // Centre column carries double weight
    function automatic weight_t kernel_weight(input int row, input int col);
        weight_t base;
        case (row)
            0:       base = 4'sd2;
            1:       base = 4'sd1;
            3:       base = -4'sd1;
            4:       base = -4'sd2;
            default: base = 4'sd0;
        endcase
        if (col == `EF_KERNEL_N / 2) begin
            return base + base;
        end
        return base;
    endfunction

endpackage

/* pipe_delay.sv */
`timescale 1ns/1ps

`include "edge_filter_defines.svh"

module pipe_delay #(
    parameter type payload_t = logic,
    parameter int  depth     = `EF_EXEC_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in,
    output payload_t out
);

    payload_t stage [depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= in;
            // Each entry moves one step per cycle
            for (int i = 1; i < depth; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out = stage[depth-1];

endmodule

/* window_decode.sv */
`timescale 1ns/1ps

`include "edge_filter_defines.svh"

module window_decode
    import edge_filter_pkg::*;
#(
    parameter int line_width = `EF_LINE_WIDTH
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      valid_in,
    input  logic      ready_in,
    input  logic      sop_in,
    input  logic      eop_in,
    input  mode_t     mode_in,
    input  pixel_t    data_in,
    output logic      ready_out,
    output logic      win_valid,
    output channel_t  [`EF_KERNEL_N*`EF_KERNEL_N-1:0] win_r,
    output channel_t  [`EF_KERNEL_N*`EF_KERNEL_N-1:0] win_g,
    output channel_t  [`EF_KERNEL_N*`EF_KERNEL_N-1:0] win_b,
    output sideband_t win_side,
    output pixel_t    win_pixel
);

    localparam int n       = `EF_KERNEL_N;
    localparam int taps    = n * n;
    // Four full lines plus one partial window row
    localparam int buf_len = (n - 1) * line_width + n;

    logic     accept;
    channel_t red_in;
    channel_t green_in;
    channel_t blue_in;

    // Index 0 is the oldest pixel
    channel_t buf_r [buf_len];
    channel_t buf_g [buf_len];
    channel_t buf_b [buf_len];

    assign ready_out = ready_in;
    assign accept    = valid_in && ready_in;

    assign red_in   = data_in[3*`EF_CH_W-1 -: `EF_CH_W];
    assign green_in = data_in[2*`EF_CH_W-1 -: `EF_CH_W];
    assign blue_in  = data_in[`EF_CH_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < buf_len; i++) begin
                buf_r[i] <= '0;
                buf_g[i] <= '0;
                buf_b[i] <= '0;
            end
        end else if (accept) begin
            for (int i = 0; i < buf_len - 1; i++) begin
                buf_r[i] <= buf_r[i+1];
                buf_g[i] <= buf_g[i+1];
                buf_b[i] <= buf_b[i+1];
            end
            buf_r[buf_len-1] <= red_in;
            buf_g[buf_len-1] <= green_in;
            buf_b[buf_len-1] <= blue_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= accept;
        end
    end

    // Taps are read from the buffer as it looks after this shift,
    // so the newest tap is the pixel being accepted
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int t = 0; t < taps - 1; t++) begin
                win_r[t] <= buf_r[(t / n) * line_width + t % n + 1];
                win_g[t] <= buf_g[(t / n) * line_width + t % n + 1];
                win_b[t] <= buf_b[(t / n) * line_width + t % n + 1];
            end
            win_r[taps-1] <= red_in;
            win_g[taps-1] <= green_in;
            win_b[taps-1] <= blue_in;
            win_side      <= '{valid: valid_in, sop: sop_in, eop: eop_in, mode: mode_in};
            win_pixel     <= data_in;
        end
    end

endmodule

/* conv_execute.sv */
`timescale 1ns/1ps

`include "edge_filter_defines.svh"

module conv_execute
    import edge_filter_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  channel_t [`EF_KERNEL_N*`EF_KERNEL_N-1:0] win_r,
    input  channel_t [`EF_KERNEL_N*`EF_KERNEL_N-1:0] win_g,
    input  channel_t [`EF_KERNEL_N*`EF_KERNEL_N-1:0] win_b,
    output sum_t     sum3_r,
    output sum_t     sum3_g,
    output sum_t     sum3_b,
    output sum_t     sum5_r,
    output sum_t     sum5_g,
    output sum_t     sum5_b
);

    localparam int n    = `EF_KERNEL_N;
    localparam int taps = n * n;
    localparam int half = n / 2;
    localparam int ch_n = 3;

    channel_t [taps-1:0] win [ch_n];

    // Stage 1 row partial sums, full width and inner three columns
    sum_t row5 [ch_n][n];
    sum_t row3 [ch_n][3];

    sum_t tot5 [ch_n];
    sum_t tot3 [ch_n];
    sum_t sum5_q [ch_n];
    sum_t sum3_q [ch_n];

    // Pixel is unsigned, so zero-extend before the signed multiply
    function automatic sum_t tap_product(input channel_t px, input int row, input int col);
        return sum_t'(signed'({1'b0, px})) * sum_t'(kernel_weight(row, col));
    endfunction

    function automatic sum_t row_sum(input channel_t [taps-1:0] w, input int row,
                                     input int lo, input int hi);
        sum_t acc;
        acc = '0;
        for (int c = lo; c <= hi; c++) begin
            acc += tap_product(w[row * n + c], row, c);
        end
        return acc;
    endfunction

    assign win[0] = win_r;
    assign win[1] = win_g;
    assign win[2] = win_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int ch = 0; ch < ch_n; ch++) begin
                for (int r = 0; r < n; r++) begin
                    row5[ch][r] <= '0;
                end
                for (int k = 0; k < 3; k++) begin
                    row3[ch][k] <= '0;
                end
            end
        end else begin
            for (int ch = 0; ch < ch_n; ch++) begin
                for (int r = 0; r < n; r++) begin
                    row5[ch][r] <= row_sum(win[ch], r, 0, n - 1);
                end
                // 3x3 sits on the centre rows and columns
                for (int k = 0; k < 3; k++) begin
                    row3[ch][k] <= row_sum(win[ch], half - 1 + k, half - 1, half + 1);
                end
            end
        end
    end

    always_comb begin
        for (int ch = 0; ch < ch_n; ch++) begin
            tot5[ch] = '0;
            tot3[ch] = '0;
            for (int r = 0; r < n; r++) begin
                tot5[ch] += row5[ch][r];
            end
            for (int k = 0; k < 3; k++) begin
                tot3[ch] += row3[ch][k];
            end
        end
    end

    // Stage 2 row totals
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < ch_n; ch++) begin
            if (rst) begin
                sum5_q[ch] <= '0;
                sum3_q[ch] <= '0;
            end else begin
                sum5_q[ch] <= tot5[ch];
                sum3_q[ch] <= tot3[ch];
            end
        end
    end

    assign sum5_r = sum5_q[0];
    assign sum5_g = sum5_q[1];
    assign sum5_b = sum5_q[2];
    assign sum3_r = sum3_q[0];
    assign sum3_g = sum3_q[1];
    assign sum3_b = sum3_q[2];

endmodule

/* edge_result.sv */
`timescale 1ns/1ps

`include "edge_filter_defines.svh"

module edge_result
    import edge_filter_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  sideband_t side,
    input  pixel_t    pixel,
    input  sum_t      sum3_r,
    input  sum_t      sum3_g,
    input  sum_t      sum3_b,
    input  sum_t      sum5_r,
    input  sum_t      sum5_g,
    input  sum_t      sum5_b,
    output logic      valid_out,
    output logic      sop_out,
    output logic      eop_out,
    output pixel_t    data_out
);

    localparam sum_t thresh_3x3 = sum_t'(`EF_THRESH_3X3);
    localparam sum_t thresh_5x5 = sum_t'(`EF_THRESH_5X5);

    pixel_t next_pixel;

    // Full nibble at or above the limit, negative sums give zero
    function automatic channel_t binarize(input sum_t s, input sum_t limit);
        return (s >= limit) ? {`EF_CH_W{1'b1}} : '0;
    endfunction

    always_comb begin
        case (side.mode)
            MODE_PASS: next_pixel = pixel;
            MODE_3X3: next_pixel = {binarize(sum3_r, thresh_3x3),
                                    binarize(sum3_g, thresh_3x3),
                                    binarize(sum3_b, thresh_3x3)};
            // Both 5x5 encodings
            default: next_pixel = {binarize(sum5_r, thresh_5x5),
                                   binarize(sum5_g, thresh_5x5),
                                   binarize(sum5_b, thresh_5x5)};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
            sop_out   <= 1'b0;
            eop_out   <= 1'b0;
        end else begin
            valid_out <= side.valid;
            // Markers only count on a valid beat
            sop_out   <= side.valid && side.sop;
            eop_out   <= side.valid && side.eop;
        end
    end

    always_ff @(posedge clk) begin
        data_out <= next_pixel;
    end

endmodule

/* edge_filter.sv */
`timescale 1ns/1ps

`include "edge_filter_defines.svh"

module edge_filter
    import edge_filter_pkg::*;
#(
    parameter int line_width = `EF_LINE_WIDTH
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   valid_in,
    input  logic   ready_in,
    input  logic   sop_in,
    input  logic   eop_in,
    input  mode_t  mode_in,
    input  pixel_t data_in,
    output logic   ready_out,
    output logic   valid_out,
    output logic   sop_out,
    output logic   eop_out,
    output pixel_t data_out
);

    localparam int taps = `EF_KERNEL_N * `EF_KERNEL_N;

    logic                 win_valid;
    channel_t [taps-1:0]  win_r;
    channel_t [taps-1:0]  win_g;
    channel_t [taps-1:0]  win_b;
    sideband_t            win_side;
    pixel_t               win_pixel;

    sideband_t side_in;
    sideband_t res_side;
    pixel_t    res_pixel;

    sum_t sum3_r;
    sum_t sum3_g;
    sum_t sum3_b;
    sum_t sum5_r;
    sum_t sum5_g;
    sum_t sum5_b;

    window_decode #(
        .line_width (line_width)
    ) u_decode (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .sop_in    (sop_in),
        .eop_in    (eop_in),
        .mode_in   (mode_in),
        .data_in   (data_in),
        .ready_out (ready_out),
        .win_valid (win_valid),
        .win_r     (win_r),
        .win_g     (win_g),
        .win_b     (win_b),
        .win_side  (win_side),
        .win_pixel (win_pixel)
    );

    conv_execute u_execute (
        .clk    (clk),
        .rst    (rst),
        .win_r  (win_r),
        .win_g  (win_g),
        .win_b  (win_b),
        .sum3_r (sum3_r),
        .sum3_g (sum3_g),
        .sum3_b (sum3_b),
        .sum5_r (sum5_r),
        .sum5_g (sum5_g),
        .sum5_b (sum5_b)
    );

    // Window sideband holds between accepts, the valid comes from the strobe
    assign side_in = '{valid: win_valid, sop: win_side.sop, eop: win_side.eop,
                       mode: win_side.mode};

    // Sideband and raw pixel ride alongside the execute stages
    pipe_delay #(
        .payload_t (sideband_t),
        .depth     (`EF_EXEC_DEPTH)
    ) u_side_delay (
        .clk (clk),
        .rst (rst),
        .in  (side_in),
        .out (res_side)
    );

    pipe_delay #(
        .payload_t (pixel_t),
        .depth     (`EF_EXEC_DEPTH)
    ) u_pixel_delay (
        .clk (clk),
        .rst (rst),
        .in  (win_pixel),
        .out (res_pixel)
    );

    edge_result u_result (
        .clk       (clk),
        .rst       (rst),
        .side      (res_side),
        .pixel     (res_pixel),
        .sum3_r    (sum3_r),
        .sum3_g    (sum3_g),
        .sum3_b    (sum3_b),
        .sum5_r    (sum5_r),
        .sum5_g    (sum5_g),
        .sum5_b    (sum5_b),
        .valid_out (valid_out),
        .sop_out   (sop_out),
        .eop_out   (eop_out),
        .data_out  (data_out)
    );

endmodule

/* edge_filter_properties.sv */
`timescale 1ns/1ps

`include "edge_filter_defines.svh"

module edge_filter_properties (
    input logic clk,
    input logic rst,
    input logic valid_in,
    input logic ready_in,
    input logic ready_out,
    input logic valid_out
);

    localparam int latency = `EF_EXEC_DEPTH + 2;

    int unsigned fail_count = 0;

    quiet_in_reset: assert property (@(posedge clk) rst |=> !valid_out)
        else begin
            $error("valid_out high right after a reset cycle");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk) $fell(rst) |=> !valid_out)
        else begin
            $error("valid_out high in the first cycle after reset");
            fail_count++;
        end

    // Upstream ready is a straight wire
    ready_mirror: assert property (@(posedge clk) ready_out == ready_in)
        else begin
            $error("ready_out differs from ready_in");
            fail_count++;
        end

    fixed_latency: assert property (@(posedge clk) disable iff (rst)
        valid_out == $past(valid_in && ready_in, latency))
        else begin
            $error("valid_out does not follow acceptance by the pipeline latency");
            fail_count++;
        end

endmodule

/* edge_filter_checker.sv */
`timescale 1ns/1ps

`include "edge_filter_defines.svh"

module edge_filter_checker
    import edge_filter_pkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   valid_out,
    input logic   sop_out,
    input logic   eop_out,
    input pixel_t data_out
);

    typedef struct packed {
        int     test;
        logic   sop;
        logic   eop;
        pixel_t data;
    } expect_t;

    expect_t exp_q [$];

    int cur_test     = -1;
    int cur_outputs  = 0;
    int cur_errors   = 0;
    int checks       = 0;
    int errors       = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    function automatic void push_expect(input int test, input pixel_t data,
                                        input logic sop, input logic eop);
        exp_q.push_back('{test: test, sop: sop, eop: eop, data: data});
    endfunction

    function automatic int pending();
        return exp_q.size();
    endfunction

    // Closes the open test and prints its line
    function automatic void finish_test();
        if (cur_test >= 0) begin
            if (cur_errors == 0) begin
                tests_passed++;
                $display("test %0d ok: %0d outputs checked", cur_test, cur_outputs);
            end else begin
                tests_failed++;
                $display("test %0d failed: %0d mismatches over %0d outputs",
                         cur_test, cur_errors, cur_outputs);
            end
        end
        cur_test    = -1;
        cur_outputs = 0;
        cur_errors  = 0;
    endfunction

    function automatic void check_leftover();
        if (exp_q.size() != 0) begin
            $display("%0d expected outputs never appeared on valid_out", exp_q.size());
            errors++;
        end
    endfunction

    function automatic void compare_field(input string name, input logic [11:0] expected,
                                          input logic [11:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
            cur_errors++;
        end
    endfunction

    // Outputs change on the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        expect_t head;
        if (!rst) begin
            if (valid_out) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected output at %0t: data_out %0h arrived with nothing expected",
                             $time, data_out);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    if (head.test != cur_test) begin
                        finish_test();
                        cur_test = head.test;
                    end
                    cur_outputs++;
                    compare_field("data_out", head.data, data_out);
                    compare_field("sop_out", 12'(head.sop), 12'(sop_out));
                    compare_field("eop_out", 12'(head.eop), 12'(eop_out));
                end
            end else if (sop_out || eop_out) begin
                $display("packet marker at %0t: sop_out or eop_out high while valid_out is low",
                         $time);
                errors++;
            end
        end
    end

endmodule

/* tb_edge_filter.sv */
`timescale 1ns/1ps

`include "edge_filter_defines.svh"

module tb_edge_filter
    import edge_filter_pkg::*;
();

    localparam int line_width   = 8;
    localparam int buf_len      = (`EF_KERNEL_N - 1) * line_width + `EF_KERNEL_N;
    localparam int reset_cycles = 4;
    // Window register, execute stages, output register
    localparam int latency      = `EF_EXEC_DEPTH + 2;

    typedef struct packed {
        int     test;
        logic   valid;
        logic   ready;
        logic   sop;
        logic   eop;
        mode_t  mode;
        pixel_t pixel;
    } stim_t;

    logic   clk;
    logic   rst;
    logic   valid_in;
    logic   ready_in;
    logic   sop_in;
    logic   eop_in;
    mode_t  mode_in;
    pixel_t data_in;
    logic   ready_out;
    logic   valid_out;
    logic   sop_out;
    logic   eop_out;
    pixel_t data_out;

    stim_t  stim [$];
    // Reference copy of the line buffer, index 0 oldest
    pixel_t model_buf [buf_len];
    int     cycles = 0;
    int     cycle_limit;

    edge_filter #(
        .line_width (line_width)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .sop_in    (sop_in),
        .eop_in    (eop_in),
        .mode_in   (mode_in),
        .data_in   (data_in),
        .ready_out (ready_out),
        .valid_out (valid_out),
        .sop_out   (sop_out),
        .eop_out   (eop_out),
        .data_out  (data_out)
    );

    edge_filter_checker chk (
        .clk       (clk),
        .rst       (rst),
        .valid_out (valid_out),
        .sop_out   (sop_out),
        .eop_out   (eop_out),
        .data_out  (data_out)
    );

    bind edge_filter edge_filter_properties u_props (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .ready_out (ready_out),
        .valid_out (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic void add_entry(input int test, input logic valid, input logic ready,
                                      input logic sop, input logic eop, input mode_t mode,
                                      input pixel_t pixel);
        stim.push_back('{test: test, valid: valid, ready: ready, sop: sop, eop: eop,
                         mode: mode, pixel: pixel});
    endfunction

    task automatic build_table();
        int       y;
        int       x;
        channel_t r;
        pixel_t   px;
        // Ramp right after reset, windows still hold the zero buffer
        for (int i = 0; i < 16; i++) begin
            px = {4'(i), 4'(15 - i), 4'(i / 2)};
            add_entry(1, 1'b1, 1'b1, i == 0, i == 15, MODE_5X5, px);
        end
        for (int i = 0; i < 16; i++) begin
            px = {4'(i * 3), 4'(i * 5 + 1), 4'(i * 7 + 2)};
            add_entry(2, 1'b1, 1'b1, i == 0, i == 15, MODE_PASS, px);
        end
        // Horizontal bands of different height per channel
        for (int i = 0; i < 48; i++) begin
            y  = i / line_width;
            r  = ((y / 2) % 2 == 0) ? 4'hf : 4'h0;
            px = {r, (y % 3 == 0) ? 4'hf : 4'h0, ~r};
            add_entry(3, 1'b1, 1'b1, i == 0, i == 47, MODE_3X3, px);
        end
        // Vertical ramps, both 5x5 encodings line by line
        for (int i = 0; i < 48; i++) begin
            y  = i / line_width;
            x  = i % line_width;
            px = {4'(y * 3), 4'(15 - 2 * y), 4'(y * 4 + x)};
            add_entry(4, 1'b1, 1'b1, i == 0, i == 47,
                      (y % 2 == 1) ? MODE_5X5_ALT : MODE_5X5, px);
        end
        for (int i = 0; i < 32; i++) begin
            add_entry(5, 1'b1, 1'b1, i == 0, i == 31, MODE_3X3, 12'($urandom));
        end
        for (int i = 0; i < 48; i++) begin
            add_entry(6, 1'b1, 1'b1, i == 0, i == 47,
                      mode_t'(2'($urandom_range(0, 3))), 12'($urandom));
        end
        // Random gaps on both valid and ready
        for (int i = 0; i < 48; i++) begin
            add_entry(7, $urandom_range(0, 4) != 0, $urandom_range(0, 2) != 0, i == 0, i == 47,
                      mode_t'(2'($urandom_range(1, 3))), 12'($urandom));
        end
    endtask

    task automatic shift_model(input pixel_t px);
        for (int i = 0; i < buf_len - 1; i++) begin
            model_buf[i] = model_buf[i+1];
        end
        model_buf[buf_len-1] = px;
    endtask

    // Square window from lo to hi in both rows and columns
    function automatic int channel_sum(input int ch, input int lo, input int hi);
        int     acc;
        pixel_t px;
        acc = 0;
        for (int r = lo; r <= hi; r++) begin
            for (int c = lo; c <= hi; c++) begin
                px = model_buf[r * line_width + c];
                acc += int'(px[ch*4 +: 4]) * int'(kernel_weight(r, c));
            end
        end
        return acc;
    endfunction

    function automatic pixel_t expected_pixel(input mode_t mode, input pixel_t px);
        pixel_t res;
        int     s;
        if (mode == MODE_PASS) begin
            return px;
        end
        for (int ch = 0; ch < 3; ch++) begin
            if (mode == MODE_3X3) begin
                s = channel_sum(ch, 1, 3);
                res[ch*4 +: 4] = (s >= `EF_THRESH_3X3) ? 4'hf : 4'h0;
            end else begin
                s = channel_sum(ch, 0, 4);
                res[ch*4 +: 4] = (s >= `EF_THRESH_5X5) ? 4'hf : 4'h0;
            end
        end
        return res;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int total_errors;
        void'($urandom(24184));
        rst      = 1'b1;
        valid_in = 1'b0;
        ready_in = 1'b0;
        sop_in   = 1'b0;
        eop_in   = 1'b0;
        mode_in  = MODE_PASS;
        data_in  = '0;
        for (int i = 0; i < buf_len; i++) begin
            model_buf[i] = '0;
        end
        build_table();
        cycle_limit = stim.size() + reset_cycles + latency + 20;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        foreach (stim[i]) begin
            @(negedge clk);
            valid_in = stim[i].valid;
            ready_in = stim[i].ready;
            sop_in   = stim[i].sop;
            eop_in   = stim[i].eop;
            mode_in  = stim[i].mode;
            data_in  = stim[i].pixel;
            if (stim[i].valid && stim[i].ready) begin
                shift_model(stim[i].pixel);
                chk.push_expect(stim[i].test, expected_pixel(stim[i].mode, stim[i].pixel),
                                stim[i].sop, stim[i].eop);
            end
        end
        @(negedge clk);
        valid_in = 1'b0;
        sop_in   = 1'b0;
        eop_in   = 1'b0;
        while (chk.pending() != 0) begin
            @(negedge clk);
        end
        // Room for any stray output to show up
        repeat (latency + 2) @(negedge clk);
        chk.finish_test();
        chk.check_leftover();
        total_errors = chk.errors + dut.u_props.fail_count;
        $display("summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 chk.tests_passed, chk.tests_failed, chk.checks, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
edge_filter_pkg.sv
pipe_delay.sv
window_decode.sv
conv_execute.sv
edge_result.sv
edge_filter.sv
edge_filter_properties.sv
edge_filter_checker.sv
tb_edge_filter.sv

/* run_sim.sh */
#!/bin/sh
# Builds the edge filter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing -Wno-fatal --top-module tb_edge_filter \
        -f compile.f -o sim_edge_filter; then
    echo "Verilator build failed"
    exit 1
fi

# Raised error limit lets the testbench reach its own summary
if ! output=$(./obj_dir/sim_edge_filter +verilator+error+limit+1000); then
    echo "$output"
    echo "Simulation exited with an error status"
    exit 1
fi

echo "$output"

if echo "$output" | grep -qx "All tests passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
